//--- synth_display.f
+incdir+design
design/video_pkg.sv
design/keyboard_pkg.sv
design/vga_timing.sv
design/key_row.sv
design/control_overlay.sv
design/pixel_compositor.sv
design/synth_display.sv
sim/synth_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f synth_display.f \
	--top-module synth_display_tb -o synth_display_sim > build.log 2>&1 &&
	./obj_dir/synth_display_sim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log &&
	echo "Simulation passed" ||
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- sim/synth_display_tb.sv
`timescale 1ns/100ps
`default_nettype none

module synth_display_tb;
	import video_pkg::*;
	import keyboard_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int FRAME_CYCLES = 800 * 525;
	localparam int WATCHDOG_NS  = 4 * FRAME_CYCLES * CLK_PERIOD;   // Four frames
	localparam int NUM_PROBES   = 9;

	logic       VGA_CLK;
	logic       rst;
	scan_t      scan_code1;
	scan_t      scan_code2;
	scan_t      scan_code3;
	scan_t      scan_code4;
	logic [7:0] slide_val;
	logic [3:0] cursor_col;
	logic [3:0] cursor_row;
	logic       hs;
	logic       vs;
	rgb_t       rgb;

	int cnt_x;      // Mirror of the DUT counters
	int cnt_y;
	int ref_x;      // Position whose pixel is on the outputs now
	int ref_y;
	bit ref_valid;
	bit rst_seen;
	int phase;      // Input set in use
	int probe_id;
	bit probe_seen [1:NUM_PROBES];
	int sync_errs;
	int blank_errs;
	int pixel_errs;
	int missed;

	synth_display dut_i (
		.VGA_CLK    (VGA_CLK),
		.rst        (rst),
		.scan_code1 (scan_code1),
		.scan_code2 (scan_code2),
		.scan_code3 (scan_code3),
		.scan_code4 (scan_code4),
		.slide_val  (slide_val),
		.cursor_col (cursor_col),
		.cursor_row (cursor_row),
		.hs         (hs),
		.vs         (vs),
		.rgb        (rgb)
	);

	always #(CLK_PERIOD / 2) VGA_CLK = ~VGA_CLK;

	// Counters at 800x525 with outputs one cycle behind them
	always @(posedge VGA_CLK) begin
		if (rst) begin
			cnt_x     <= 0;
			cnt_y     <= 0;
			ref_valid <= 1'b0;
			rst_seen  <= 1'b1;
		end else begin
			ref_x     <= cnt_x;
			ref_y     <= cnt_y;
			ref_valid <= 1'b1;
			if (cnt_x == 799) begin
				cnt_x <= 0;
				cnt_y <= (cnt_y == 524) ? 0 : cnt_y + 1;
			end else begin
				cnt_x <= cnt_x + 1;
			end
		end
	end

	function automatic logic hs_level(int px);
		return !(px >= 656 && px <= 751);   // 96 pixel pulse
	endfunction

	function automatic logic vs_level(int py);
		return !(py == 490 || py == 491);
	endfunction

	// Checked pixels of each input set
	function automatic int probe_at(int ph, int px, int py);
		if (ph == 1 && px == 20 && py == 420)
			return 1;   // White slot 0 below idle black slot 0
		if (ph == 1 && px == 20 && py == 475)
			return 2;   // Under idle white key
		if (ph == 1 && px == 100 && py == 425)
			return 3;   // White slot 3 under idle black slot 4
		if (ph == 1 && px == 405 && py == 305)
			return 4;   // Knob at 100 + 600*64/128
		if (ph == 1 && px == 200 && py == 305)
			return 5;
		if (ph == 1 && px == 130 && py == 20)
			return 6;   // Cell x 128..191, y 16..32
		if (ph == 1 && px == 200 && py == 20)
			return 7;
		if (ph == 2 && px == 20 && py == 475)
			return 8;   // Scan code 37 plays white slot 0
		if (ph == 2 && px == 100 && py == 425)
			return 9;   // Scan code 3D plays black slot 4
		return 0;
	endfunction

	// R, G, B of the colour each checked pixel must show
	function automatic rgb_t expected_rgb(int id);
		rgb_t c;
		case (id)
			1, 3, 5, 8: c = {10'h1f0, 10'h1f0, 10'h1f0};   // White key and track
			4:          c = {10'h100, 10'h130, 10'h1f0};
			6:          c = {10'h1f0, 10'h1f0, 10'h1f0};
			9:          c = {10'h010, 10'h020, 10'h0f0};
			default:    c = '0;
		endcase
		return c;
	endfunction

	function automatic string probe_name(int id);
		case (id)
			1:       return "white_key_idle";
			2:       return "white_key_below";
			3:       return "black_key_idle";
			4:       return "slider_knob";
			5:       return "slider_track";
			6:       return "cursor_cell";
			7:       return "cursor_outside";
			8:       return "white_key_played";
			9:       return "black_key_played";
			default: return "none";
		endcase
	endfunction

	always_comb probe_id = ref_valid ? probe_at(phase, ref_x, ref_y) : 0;

	always @(posedge VGA_CLK) begin
		if (probe_id != 0)
			probe_seen[probe_id] <= 1'b1;
	end

	a_reset: assert property (@(posedge VGA_CLK)
		(rst_seen && !ref_valid) |-> (hs && vs && rgb == '0))
		else begin
			sync_errs++;
			$display("ERROR reset_outputs: expected hs=1 vs=1 rgb=0, actual hs=%b vs=%b rgb=%h",
				$sampled(hs), $sampled(vs), $sampled(rgb));
		end

	a_hsync: assert property (@(posedge VGA_CLK) ref_valid |-> (hs == hs_level(ref_x)))
		else begin
			sync_errs++;
			$display("ERROR hsync: expected %b, actual %b at x=%0d y=%0d",
				hs_level($sampled(ref_x)), $sampled(hs), $sampled(ref_x), $sampled(ref_y));
		end

	a_vsync: assert property (@(posedge VGA_CLK) ref_valid |-> (vs == vs_level(ref_y)))
		else begin
			sync_errs++;
			$display("ERROR vsync: expected %b, actual %b at x=%0d y=%0d",
				vs_level($sampled(ref_y)), $sampled(vs), $sampled(ref_x), $sampled(ref_y));
		end

	a_blank: assert property (@(posedge VGA_CLK)
		(ref_valid && !(ref_x < 640 && ref_y < 480)) |-> (rgb == '0))
		else begin
			blank_errs++;
			$display("ERROR blanking: expected 0, actual %h at x=%0d y=%0d",
				$sampled(rgb), $sampled(ref_x), $sampled(ref_y));
		end

	a_probe: assert property (@(posedge VGA_CLK)
		(probe_id != 0) |-> (rgb == expected_rgb(probe_id)))
		else begin
			pixel_errs++;
			$display("ERROR %s: expected %h, actual %h", probe_name($sampled(probe_id)),
				expected_rgb($sampled(probe_id)), $sampled(rgb));
		end

	// Returns on the falling edge where the outputs show the start of a line
	task automatic wait_for_line(input int line);
		do
			@(negedge VGA_CLK);
		while (!(ref_valid && ref_x == 0 && ref_y == line));
	endtask

	initial begin
		VGA_CLK    = 1'b0;
		rst        = 1'b1;
		scan_code1 = 8'h00;
		scan_code2 = 8'h00;
		scan_code3 = 8'h00;
		scan_code4 = 8'h00;
		slide_val  = 8'd64;
		cursor_col = 4'd2;
		cursor_row = 4'd1;
		phase      = 1;
		repeat (3) @(posedge VGA_CLK);
		@(negedge VGA_CLK);
		rst = 1'b0;
		wait_for_line(500);   // Inputs change in vertical blanking only
		scan_code2 = 8'h37;
		scan_code4 = 8'h3d;
		phase      = 2;
		wait_for_line(500);
		for (int i = 1; i <= NUM_PROBES; i++) begin
			if (!probe_seen[i]) begin
				missed++;
				$display("Pixel check %s was never reached", probe_name(i));
			end
		end
		$display("Errors: sync %0d, blanking %0d, pixel %0d, missed checks %0d",
			sync_errs, blank_errs, pixel_errs, missed);
		if (sync_errs + blank_errs + pixel_errs + missed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the run did not finish within four frames");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/synth_display.sv
`timescale 1ns/100ps
`default_nettype none

module synth_display (
	input  wire                  VGA_CLK,
	input  wire                  rst,
	input  keyboard_pkg::scan_t  scan_code1,
	input  keyboard_pkg::scan_t  scan_code2,
	input  keyboard_pkg::scan_t  scan_code3,
	input  keyboard_pkg::scan_t  scan_code4,
	input  logic [7:0]           slide_val,
	input  logic [3:0]           cursor_col,
	input  logic [3:0]           cursor_row,
	output logic                 hs,
	output logic                 vs,
	output video_pkg::rgb_t      rgb
);
	import video_pkg::*;
	import keyboard_pkg::*;

	coord_t x;
	coord_t y;
	logic   active;
	logic   hs_raw;
	logic   vs_raw;
	logic   white_hit;
	logic   black_hit;
	logic   slider_hit;
	logic   track_hit;
	logic   cursor_hit;

	vga_timing timing_i (
		.VGA_CLK (VGA_CLK),
		.rst     (rst),
		.x       (x),
		.y       (y),
		.active  (active),
		.hs_raw  (hs_raw),
		.vs_raw  (vs_raw)
	);

	key_row #(.ROW(WHITE_ROW), .key_t(white_key_t)) white_keys (
		.x          (x),
		.y          (y),
		.scan_code1 (scan_code1),
		.scan_code2 (scan_code2),
		.scan_code3 (scan_code3),
		.scan_code4 (scan_code4),
		.key_hit    (white_hit)
	);

	key_row #(.ROW(BLACK_ROW), .key_t(black_key_t)) black_keys (
		.x          (x),
		.y          (y),
		.scan_code1 (scan_code1),
		.scan_code2 (scan_code2),
		.scan_code3 (scan_code3),
		.scan_code4 (scan_code4),
		.key_hit    (black_hit)
	);

	control_overlay controls_i (
		.x          (x),
		.y          (y),
		.slide_val  (slide_val),
		.cursor_col (cursor_col),
		.cursor_row (cursor_row),
		.slider_hit (slider_hit),
		.track_hit  (track_hit),
		.cursor_hit (cursor_hit)
	);

	// Only registered stage, adds the one cycle of latency
	pixel_compositor compositor_i (
		.VGA_CLK    (VGA_CLK),
		.rst        (rst),
		.active     (active),
		.hs_raw     (hs_raw),
		.vs_raw     (vs_raw),
		.white_hit  (white_hit),
		.black_hit  (black_hit),
		.slider_hit (slider_hit),
		.track_hit  (track_hit),
		.cursor_hit (cursor_hit),
		.hs         (hs),
		.vs         (vs),
		.rgb        (rgb)
	);

endmodule

`default_nettype wire

//--- design/pixel_compositor.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_compositor (
	input  wire              VGA_CLK,
	input  wire              rst,
	input  logic             active,
	input  logic             hs_raw,
	input  logic             vs_raw,
	input  logic             white_hit,
	input  logic             black_hit,
	input  logic             slider_hit,
	input  logic             track_hit,
	input  logic             cursor_hit,
	output logic             hs,
	output logic             vs,
	output video_pkg::rgb_t  rgb
);
	import video_pkg::*;

	logic        w_key;      // White key not covered by a black one
	logic        any_key;
	colour_idx_t colour;
	logic        active_q;

	assign w_key   = white_hit && !black_hit;
	assign any_key = white_hit || black_hit;

	always_comb begin
		if (!active)
			colour = BACKGROUND;
		else if (slider_hit)
			colour = SLIDER;
		else if (cursor_hit)
			colour = CURSOR;
		else if (track_hit || w_key)
			colour = WHITE_KEY;   // Track shares the white key colour
		else if (any_key)
			colour = BLACK_KEY;
		else
			colour = BACKGROUND;
	end

	always_ff @(posedge VGA_CLK) begin
		if (rst) begin
			hs       <= 1'b1;
			vs       <= 1'b1;
			rgb      <= '0;
			active_q <= 1'b0;
		end else begin
			hs       <= hs_raw;
			vs       <= vs_raw;
			rgb      <= PALETTE[colour];
			active_q <= active;
		end
	end

	// Blanking must reach the DAC aligned with the delayed syncs
	a_blank_black: assert property (@(posedge VGA_CLK) disable iff (rst)
		!active_q |-> (rgb == '0))
		else $error("rgb %h outside active area", rgb);

endmodule

`default_nettype wire

//--- design/control_overlay.sv
`timescale 1ns/100ps
`default_nettype none

`include "synth_display_cfg.svh"

module control_overlay (
	input  video_pkg::coord_t  x,
	input  video_pkg::coord_t  y,
	input  logic [7:0]         slide_val,
	input  logic [3:0]         cursor_col,
	input  logic [3:0]         cursor_row,
	output logic               slider_hit,
	output logic               track_hit,
	output logic               cursor_hit
);
	import video_pkg::*;

	localparam coord_t TRACK_X0 = coord_t'(`SLIDER_X0);
	localparam coord_t TRACK_X1 = coord_t'(`SLIDER_X0 + `SLIDER_LEN);
	localparam coord_t TRACK_Y0 = coord_t'(`SLIDER_Y0);
	localparam coord_t TRACK_Y1 = coord_t'(`SLIDER_Y0 + `SLIDER_H);

	logic [17:0] knob_prod;   // Up to 600 * 255
	coord_t      knob_x;
	coord_t      cell_x0;
	coord_t      cell_y0;
	logic        on_track_lines;

	// Full scale of slide_val is 128, larger values run past the track
	assign knob_prod = 18'(`SLIDER_LEN) * 18'(slide_val);
	assign knob_x    = TRACK_X0 + coord_t'(knob_prod >> 7);

	assign on_track_lines = (y >= TRACK_Y0) && (y <= TRACK_Y1);

	assign slider_hit = on_track_lines && (x >= knob_x) && (x <= knob_x + coord_t'(`KNOB_W));
	assign track_hit  = on_track_lines && (x >= TRACK_X0) && (x <= TRACK_X1);

	assign cell_x0 = coord_t'(cursor_col) * coord_t'(`CELL_W);
	assign cell_y0 = coord_t'(cursor_row) * coord_t'(`CELL_H);

	// Bottom edge is inclusive, so the block is one line taller than a cell
	assign cursor_hit = (x >= cell_x0) && (x < cell_x0 + coord_t'(`CELL_W)) &&
	                    (y >= cell_y0) && (y <= cell_y0 + coord_t'(`CELL_H));

endmodule

`default_nettype wire

//--- design/key_row.sv
`timescale 1ns/100ps
`default_nettype none

`include "synth_display_cfg.svh"

module key_row #(
	parameter keyboard_pkg::key_row_t ROW = keyboard_pkg::WHITE_ROW,
	parameter type key_t = keyboard_pkg::white_key_t
) (
	input  video_pkg::coord_t    x,
	input  video_pkg::coord_t    y,
	input  keyboard_pkg::scan_t  scan_code1,
	input  keyboard_pkg::scan_t  scan_code2,
	input  keyboard_pkg::scan_t  scan_code3,
	input  keyboard_pkg::scan_t  scan_code4,
	output logic                 key_hit
);
	import video_pkg::*;
	import keyboard_pkg::*;

	localparam coord_t X0       = (ROW == WHITE_ROW) ? coord_t'(`WHITE_X0) : '0;
	localparam coord_t PITCH    = coord_t'(`KEY_PITCH);
	localparam coord_t WIDTH    = coord_t'(`KEY_WIDTH);
	localparam coord_t TOP      = coord_t'(`KEY_TOP);
	localparam coord_t IDLE_BOT = (ROW == WHITE_ROW) ? coord_t'(`KEY_TOP + `WHITE_IDLE_H)
	                                                 : coord_t'(`KEY_TOP + `BLACK_IDLE_H);
	localparam coord_t PLAY_BOT = (ROW == WHITE_ROW) ? coord_t'(`KEY_TOP + `WHITE_PLAY_H)
	                                                 : coord_t'(`KEY_TOP + `BLACK_PLAY_H);

	// True when s is one of the keys that exist in this row
	function automatic logic is_key(logic [3:0] s);
		key_t k;
		logic found;
		k = k.first();
		found = 1'b0;
		for (int i = 0; i < k.num(); i++) begin
			if (k == s)
				found = 1'b1;
			k = k.next();
		end
		return found;
	endfunction

	logic [3:0] ch_slot [4];   // Decoded slot per channel
	coord_t     x_rel;
	coord_t     slot_idx;
	coord_t     slot_off;
	logic [3:0] slot;
	logic       on_slot;
	logic       played;

	assign ch_slot[0] = note_slot(ROW, scan_code1);
	assign ch_slot[1] = note_slot(ROW, scan_code2);
	assign ch_slot[2] = note_slot(ROW, scan_code3);
	assign ch_slot[3] = note_slot(ROW, scan_code4);

	always_comb begin
		x_rel    = x - X0;
		slot_idx = x_rel / PITCH;
		slot_off = x_rel - slot_idx * PITCH;
		slot     = slot_idx[3:0];
		on_slot  = (x >= X0) && (slot_idx[11:4] == '0) && (slot_off < WIDTH) && is_key(slot);
		played   = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (ch_slot[i] == slot)
				played = 1'b1;   // Any channel holding this note
		end
	end

	assign key_hit = on_slot && (y >= TOP) && (y < (played ? PLAY_BOT : IDLE_BOT));

	// Decode table in the package must agree with the row's key set
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			a_slot_legal: assert (ch_slot[i] == NO_SLOT || is_key(ch_slot[i]))
				else $error("Channel %0d decodes to missing key slot %0d", i + 1, ch_slot[i]);
		end
	end

endmodule

`default_nettype wire

//--- design/vga_timing.sv
`timescale 1ns/100ps
`default_nettype none

`include "synth_display_cfg.svh"

module vga_timing (
	input  wire                 VGA_CLK,
	input  wire                 rst,
	output video_pkg::coord_t   x,
	output video_pkg::coord_t   y,
	output logic                active,
	output logic                hs_raw,
	output logic                vs_raw
);
	import video_pkg::*;

	localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
	localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);
	localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
	localparam coord_t HS_END   = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);
	localparam coord_t VS_END   = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

	coord_t h_cnt;
	coord_t v_cnt;

	always_ff @(posedge VGA_CLK) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;   // Next line or new frame
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign x = h_cnt;
	assign y = v_cnt;

	// Both syncs are active low
	assign hs_raw = !((h_cnt >= HS_START) && (h_cnt < HS_END));
	assign vs_raw = !((v_cnt >= VS_START) && (v_cnt < VS_END));
	assign active = (h_cnt < coord_t'(`H_ACTIVE)) && (v_cnt < coord_t'(`V_ACTIVE));

	a_x_range: assert property (@(posedge VGA_CLK) disable iff (rst)
		x < coord_t'(`H_TOTAL))
		else $error("x counter left the line: %0d", x);

	// Sync pulse must sit inside horizontal blanking
	a_hs_blank: assert property (@(posedge VGA_CLK) disable iff (rst)
		active |-> hs_raw)
		else $error("hs_raw low in active area at x=%0d", x);

endmodule

`default_nettype wire

//--- design/keyboard_pkg.sv
`default_nettype none

package keyboard_pkg;

	typedef logic [7:0] scan_t;

	typedef enum logic {
		WHITE_ROW = 1'b0,
		BLACK_ROW = 1'b1
	} key_row_t;

	// All 15 white slots are drawn
	typedef enum logic [3:0] {
		WK0 = 4'd0, WK1 = 4'd1, WK2 = 4'd2, WK3 = 4'd3, WK4 = 4'd4,
		WK5 = 4'd5, WK6 = 4'd6, WK7 = 4'd7, WK8 = 4'd8, WK9 = 4'd9,
		WK10 = 4'd10, WK11 = 4'd11, WK12 = 4'd12, WK13 = 4'd13, WK14 = 4'd14
	} white_key_t;

	// Black keys skip the slots between E-F and B-C
	typedef enum logic [3:0] {
		BK0 = 4'd0, BK1 = 4'd1, BK2 = 4'd2, BK4 = 4'd4, BK5 = 4'd5,
		BK7 = 4'd7, BK8 = 4'd8, BK9 = 4'd9, BK11 = 4'd11, BK12 = 4'd12,
		BK14 = 4'd14
	} black_key_t;

	localparam logic [3:0] NO_SLOT = 4'd15;

	// Scan code to key slot of one row
	function automatic logic [3:0] note_slot(key_row_t row, scan_t code);
		logic [3:0] slot;
		slot = NO_SLOT;
		if (row == WHITE_ROW) begin
			case (code)
				8'h37: slot = 4'd0;
				8'h39: slot = 4'd1;
				8'h3b: slot = 4'd2;
				8'h3c: slot = 4'd3;   // Middle C
				8'h3e: slot = 4'd4;
				8'h40: slot = 4'd5;
				8'h41: slot = 4'd6;
				8'h43: slot = 4'd7;
				8'h45: slot = 4'd8;
				8'h47: slot = 4'd9;
				8'h48: slot = 4'd10;
				default: slot = NO_SLOT;
			endcase
		end else begin
			case (code)
				8'h36: slot = 4'd0;
				8'h38: slot = 4'd1;
				8'h3a: slot = 4'd2;
				8'h3d: slot = 4'd4;
				8'h3f: slot = 4'd5;
				8'h42: slot = 4'd7;
				8'h44: slot = 4'd8;
				8'h46: slot = 4'd9;
				8'h49: slot = 4'd11;
				default: slot = NO_SLOT;
			endcase
		end
		return slot;
	endfunction

endpackage

`default_nettype wire

//--- design/video_pkg.sv
`default_nettype none

package video_pkg;

	typedef logic [11:0] coord_t;   // Pixel or line number

	// Colour index, also the palette address
	typedef enum logic [2:0] {
		BACKGROUND = 3'd0,
		BLACK_KEY  = 3'd1,
		WHITE_KEY  = 3'd2,
		CURSOR     = 3'd3,
		SLIDER     = 3'd4
	} colour_idx_t;

	typedef struct packed {
		logic [9:0] r;
		logic [9:0] g;
		logic [9:0] b;
	} rgb_t;

	// One entry per colour_idx_t value, in enum order
	localparam rgb_t PALETTE [0:4] = '{
		'{r: 10'h000, g: 10'h000, b: 10'h000},  // Background
		'{r: 10'h010, g: 10'h020, b: 10'h0f0},  // Black key, dark blue
		'{r: 10'h1f0, g: 10'h1f0, b: 10'h1f0},  // White key
		'{r: 10'h1f0, g: 10'h1f0, b: 10'h1f0},  // Cursor
		'{r: 10'h100, g: 10'h130, b: 10'h1f0}   // Slider knob
	};

endpackage

`default_nettype wire

//--- design/synth_display_cfg.svh
`ifndef SYNTH_DISPLAY_CFG_SVH
`define SYNTH_DISPLAY_CFG_SVH

// 640x480 at 60 Hz with a pixel clock near 25 MHz
`define H_ACTIVE      640
`define H_FRONT       16
`define H_SYNC        96
`define H_TOTAL       800

`define V_ACTIVE      480
`define V_FRONT       10
`define V_SYNC        2
`define V_TOTAL       525   // Lines per frame

// Both piano key rows hang from the same top line
`define KEY_TOP       370
`define KEY_PITCH     24    // Slot pitch of both rows
`define KEY_WIDTH     22    // Leaves a 2 pixel gap between keys
`define WHITE_X0      11    // White row starts half a key right of the black row

// A played key grows by 10 lines
`define WHITE_IDLE_H  100
`define WHITE_PLAY_H  110
`define BLACK_IDLE_H  50
`define BLACK_PLAY_H  60

// Horizontal slider
`define SLIDER_X0     100
`define SLIDER_Y0     300
`define SLIDER_LEN    600   // Track length
`define SLIDER_H      10
`define KNOB_W        20

// Cursor block covers one character cell
`define CELL_W        64
`define CELL_H        16

`endif
